/* design/dcache_pkg.sv */
package dcache_pkg;

    // cache geometry
    parameter int word_width  = 32;
    parameter int set_count   = 8;
    parameter int block_words = 2;
    parameter int way_count   = 2;

    localparam int idx_width    = $clog2(set_count);
    localparam int blkoff_width = $clog2(block_words);
    localparam int tag_width    = word_width - idx_width - blkoff_width - 2;

    typedef logic [word_width-1:0] word_t;

    typedef struct packed {
        logic [tag_width-1:0]    tag;
        logic [idx_width-1:0]    idx;
        logic [blkoff_width-1:0] blkoff;
        logic [1:0]              byteoff;
    } dcache_addr_t;

    typedef struct packed {
        logic                     valid;
        logic                     dirty;
        logic [tag_width-1:0]     tag;
        word_t [block_words-1:0]  data;
    } dcache_frame_t;

    typedef struct packed {
        logic         ren;
        logic         wen;
        logic         halt;
        dcache_addr_t addr;
        word_t        store;
    } cpu_req_t;

    typedef struct packed {
        logic  hit;
        logic  flushed;
        word_t load;
    } cpu_resp_t;

    typedef struct packed {
        logic         ren;
        logic         wen;
        dcache_addr_t addr;
        word_t        store;
    } mem_req_t;

    // memory stalls while dwait is high
    typedef struct packed {
        logic  dwait;
        word_t load;
    } mem_resp_t;

    typedef enum logic [2:0] {
        op_none,
        op_write_word,
        op_touch,
        op_fill_word0,
        op_fill_word1,
        op_clean,
        op_invalidate_all
    } array_op_t;

    typedef struct packed {
        array_op_t               op;
        logic                    way;
        logic [idx_width-1:0]    idx;
        logic [blkoff_width-1:0] blkoff;
        word_t                   wdata;
    } array_cmd_t;

    typedef enum logic [3:0] {
        idle,
        wb_word0,
        wb_word1,
        fill_word0,
        fill_word1,
        flush_check,
        flush_word0,
        flush_word1,
        flushed
    } ctrl_state_t;

endpackage

/* design/dcache_sets.sv */
module dcache_sets (
    input  logic                                   CLK,
    input  logic                                   n_rst,
    input  dcache_pkg::dcache_addr_t               cpu_addr,
    input  logic [dcache_pkg::idx_width-1:0]       flush_idx,
    input  dcache_pkg::array_cmd_t                 cmd,
    output logic                                   hit,
    output logic                                   hit_way,
    output dcache_pkg::word_t                      hit_word,
    output logic                                   victim_way,
    output dcache_pkg::dcache_frame_t              victim_frame,
    output dcache_pkg::dcache_frame_t [dcache_pkg::way_count-1:0] flush_frames
);

    // per-frame state bits
    logic [dcache_pkg::set_count-1:0] valid_q [dcache_pkg::way_count];
    logic [dcache_pkg::set_count-1:0] dirty_q [dcache_pkg::way_count];
    // way to replace next, per set
    logic [dcache_pkg::set_count-1:0] lru_q;

    logic [dcache_pkg::tag_width-1:0] tag_q [dcache_pkg::way_count][dcache_pkg::set_count];
    dcache_pkg::word_t data_q [dcache_pkg::way_count][dcache_pkg::set_count]
                              [dcache_pkg::block_words];

    logic [dcache_pkg::way_count-1:0] way_hit;

    // lookup for the processor address
    always_comb begin
        for (int w = 0; w < dcache_pkg::way_count; w++) begin
            way_hit[w] = valid_q[w][cpu_addr.idx] &&
                         (tag_q[w][cpu_addr.idx] == cpu_addr.tag);
        end
        hit      = |way_hit;
        hit_way  = way_hit[1];
        hit_word = data_q[hit_way][cpu_addr.idx][cpu_addr.blkoff];
    end

    assign victim_way = lru_q[cpu_addr.idx];

    always_comb begin
        victim_frame.valid = valid_q[victim_way][cpu_addr.idx];
        victim_frame.dirty = dirty_q[victim_way][cpu_addr.idx];
        victim_frame.tag   = tag_q[victim_way][cpu_addr.idx];
        for (int b = 0; b < dcache_pkg::block_words; b++) begin
            victim_frame.data[b] = data_q[victim_way][cpu_addr.idx][b];
        end
    end

    // both ways of the set under flush
    always_comb begin
        for (int w = 0; w < dcache_pkg::way_count; w++) begin
            flush_frames[w].valid = valid_q[w][flush_idx];
            flush_frames[w].dirty = dirty_q[w][flush_idx];
            flush_frames[w].tag   = tag_q[w][flush_idx];
            for (int b = 0; b < dcache_pkg::block_words; b++) begin
                flush_frames[w].data[b] = data_q[w][flush_idx][b];
            end
        end
    end

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            for (int w = 0; w < dcache_pkg::way_count; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            lru_q <= '0;
        end else begin
            case (cmd.op)
                dcache_pkg::op_write_word: begin
                    dirty_q[cmd.way][cmd.idx] <= 1'b1;
                    lru_q[cmd.idx]            <= ~cmd.way;
                end
                dcache_pkg::op_touch: begin
                    lru_q[cmd.idx] <= ~cmd.way;
                end
                // frame is unusable until the second word lands
                dcache_pkg::op_fill_word0: begin
                    valid_q[cmd.way][cmd.idx] <= 1'b0;
                    dirty_q[cmd.way][cmd.idx] <= 1'b0;
                end
                dcache_pkg::op_fill_word1: begin
                    valid_q[cmd.way][cmd.idx] <= 1'b1;
                    lru_q[cmd.idx]            <= ~cmd.way;
                end
                dcache_pkg::op_clean: begin
                    dirty_q[cmd.way][cmd.idx] <= 1'b0;
                end
                dcache_pkg::op_invalidate_all: begin
                    for (int w = 0; w < dcache_pkg::way_count; w++) begin
                        valid_q[w] <= '0;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // tag and data storage
    always_ff @(posedge CLK) begin
        case (cmd.op)
            dcache_pkg::op_write_word: begin
                data_q[cmd.way][cmd.idx][cmd.blkoff] <= cmd.wdata;
            end
            dcache_pkg::op_fill_word0: begin
                tag_q[cmd.way][cmd.idx]     <= cpu_addr.tag;
                data_q[cmd.way][cmd.idx][0] <= cmd.wdata;
            end
            dcache_pkg::op_fill_word1: begin
                data_q[cmd.way][cmd.idx][1] <= cmd.wdata;
            end
            default: begin
            end
        endcase
    end

    // refill only ever targets a way that misses
    one_way_hit: assert property (@(posedge CLK) disable iff (!n_rst) $onehot0(way_hit));

endmodule

/* design/dcache_ctrl.sv */
module dcache_ctrl (
    input  logic                                   CLK,
    input  logic                                   n_rst,
    input  dcache_pkg::cpu_req_t                   cpu_req,
    output dcache_pkg::cpu_resp_t                  cpu_resp,
    output dcache_pkg::mem_req_t                   mem_req,
    input  dcache_pkg::mem_resp_t                  mem_resp,
    input  logic                                   hit,
    input  logic                                   hit_way,
    input  dcache_pkg::word_t                      hit_word,
    input  logic                                   victim_way,
    input  dcache_pkg::dcache_frame_t              victim_frame,
    input  dcache_pkg::dcache_frame_t [dcache_pkg::way_count-1:0] flush_frames,
    output logic [dcache_pkg::idx_width-1:0]       flush_idx,
    output dcache_pkg::array_cmd_t                 cmd
);

    dcache_pkg::ctrl_state_t state, next_state;
    dcache_pkg::mem_req_t mem_next;
    logic [dcache_pkg::idx_width-1:0] flush_idx_next;
    logic flush_way, flush_way_next;
    logic flush_pick, flush_sel, access;
    dcache_pkg::dcache_frame_t flush_frame;
    dcache_pkg::dcache_addr_t victim_base, fill_base, flush_base;

    // memory request registers
    logic mem_ren_q, mem_wen_q;
    dcache_pkg::dcache_addr_t mem_addr_q;
    dcache_pkg::word_t mem_store_q;

    assign mem_req = '{ren: mem_ren_q, wen: mem_wen_q, addr: mem_addr_q, store: mem_store_q};

    assign access = cpu_req.ren || cpu_req.wen;

    // way 0 goes first when both are dirty
    assign flush_pick  = !flush_frames[0].dirty;
    assign flush_sel   = (state == dcache_pkg::flush_check) ? flush_pick : flush_way;
    assign flush_frame = flush_frames[flush_sel];

    // block base addresses
    always_comb begin
        victim_base         = cpu_req.addr;
        victim_base.tag     = victim_frame.tag;
        victim_base.blkoff  = '0;
        victim_base.byteoff = '0;
        fill_base           = cpu_req.addr;
        fill_base.blkoff    = '0;
        fill_base.byteoff   = '0;
        flush_base.tag      = flush_frame.tag;
        flush_base.idx      = flush_idx;
        flush_base.blkoff   = '0;
        flush_base.byteoff  = '0;
    end

    always_comb begin
        next_state     = state;
        mem_next       = mem_req;
        flush_idx_next = flush_idx;
        flush_way_next = flush_way;

        cmd.op     = dcache_pkg::op_none;
        cmd.way    = victim_way;
        cmd.idx    = cpu_req.addr.idx;
        cmd.blkoff = cpu_req.addr.blkoff;
        cmd.wdata  = mem_resp.load;

        cpu_resp.hit     = 1'b0;
        cpu_resp.flushed = 1'b0;
        cpu_resp.load    = hit_word;

        case (state)
            dcache_pkg::idle: begin
                if (cpu_req.halt) begin
                    next_state     = dcache_pkg::flush_check;
                    flush_idx_next = '0;
                    cmd.op         = dcache_pkg::op_invalidate_all;
                end else if (access && hit) begin
                    cpu_resp.hit = 1'b1;
                    cmd.op       = cpu_req.wen ? dcache_pkg::op_write_word : dcache_pkg::op_touch;
                    cmd.way      = hit_way;
                    cmd.wdata    = cpu_req.store;
                end else if (access) begin
                    if (victim_frame.valid && victim_frame.dirty) begin
                        next_state     = dcache_pkg::wb_word0;
                        mem_next.wen   = 1'b1;
                        mem_next.addr  = victim_base;
                        mem_next.store = victim_frame.data[0];
                    end else begin
                        next_state    = dcache_pkg::fill_word0;
                        mem_next.ren  = 1'b1;
                        mem_next.addr = fill_base;
                    end
                end
            end
            dcache_pkg::wb_word0: begin
                if (!mem_resp.dwait) begin
                    next_state           = dcache_pkg::wb_word1;
                    mem_next.addr.blkoff = 1'b1;
                    mem_next.store       = victim_frame.data[1];
                end
            end
            dcache_pkg::wb_word1: begin
                if (!mem_resp.dwait) begin
                    next_state    = dcache_pkg::fill_word0;
                    mem_next.wen  = 1'b0;
                    mem_next.ren  = 1'b1;
                    mem_next.addr = fill_base;
                end
            end
            dcache_pkg::fill_word0: begin
                if (!mem_resp.dwait) begin
                    next_state           = dcache_pkg::fill_word1;
                    cmd.op               = dcache_pkg::op_fill_word0;
                    mem_next.addr.blkoff = 1'b1;
                end
            end
            // a write miss then completes as a write hit from idle
            dcache_pkg::fill_word1: begin
                if (!mem_resp.dwait) begin
                    next_state   = dcache_pkg::idle;
                    cmd.op       = dcache_pkg::op_fill_word1;
                    mem_next.ren = 1'b0;
                end
            end
            dcache_pkg::flush_check: begin
                if (flush_frames[0].dirty || flush_frames[1].dirty) begin
                    next_state     = dcache_pkg::flush_word0;
                    flush_way_next = flush_pick;
                    mem_next.wen   = 1'b1;
                    mem_next.addr  = flush_base;
                    mem_next.store = flush_frame.data[0];
                end else if (flush_idx == '1) begin
                    next_state = dcache_pkg::flushed;
                end else begin
                    flush_idx_next = flush_idx + 1'b1;
                end
            end
            dcache_pkg::flush_word0: begin
                if (!mem_resp.dwait) begin
                    next_state           = dcache_pkg::flush_word1;
                    mem_next.addr.blkoff = 1'b1;
                    mem_next.store       = flush_frame.data[1];
                end
            end
            dcache_pkg::flush_word1: begin
                if (!mem_resp.dwait) begin
                    next_state   = dcache_pkg::flush_check;
                    cmd.op       = dcache_pkg::op_clean;
                    cmd.way      = flush_way;
                    cmd.idx      = flush_idx;
                    mem_next.wen = 1'b0;
                end
            end
            dcache_pkg::flushed: begin
                cpu_resp.flushed = 1'b1;
            end
            default: begin
                next_state = dcache_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge n_rst) begin
        if (!n_rst) begin
            state     <= dcache_pkg::idle;
            flush_idx <= '0;
            flush_way <= 1'b0;
            mem_ren_q <= 1'b0;
            mem_wen_q <= 1'b0;
        end else begin
            state     <= next_state;
            flush_idx <= flush_idx_next;
            flush_way <= flush_way_next;
            mem_ren_q <= mem_next.ren;
            mem_wen_q <= mem_next.wen;
        end
    end

    always_ff @(posedge CLK) begin
        mem_addr_q  <= mem_next.addr;
        mem_store_q <= mem_next.store;
    end

    mem_one_dir: assert property (@(posedge CLK) disable iff (!n_rst)
        !(mem_req.ren && mem_req.wen));

    // request holds until memory drops dwait
    mem_hold: assert property (@(posedge CLK) disable iff (!n_rst)
        (mem_req.ren || mem_req.wen) && mem_resp.dwait |=> $stable(mem_req));

endmodule

/* design/dcache.sv */
module dcache (
    input  logic                   CLK,
    input  logic                   n_rst,
    input  dcache_pkg::cpu_req_t   cpu_req,
    output dcache_pkg::cpu_resp_t  cpu_resp,
    output dcache_pkg::mem_req_t   mem_req,
    input  dcache_pkg::mem_resp_t  mem_resp
);

    logic hit, hit_way, victim_way;
    dcache_pkg::word_t hit_word;
    dcache_pkg::dcache_frame_t victim_frame;
    dcache_pkg::dcache_frame_t [dcache_pkg::way_count-1:0] flush_frames;
    logic [dcache_pkg::idx_width-1:0] flush_idx;
    dcache_pkg::array_cmd_t cmd;

    dcache_ctrl u_ctrl (
        .CLK          (CLK),
        .n_rst        (n_rst),
        .cpu_req      (cpu_req),
        .cpu_resp     (cpu_resp),
        .mem_req      (mem_req),
        .mem_resp     (mem_resp),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_word     (hit_word),
        .victim_way   (victim_way),
        .victim_frame (victim_frame),
        .flush_frames (flush_frames),
        .flush_idx    (flush_idx),
        .cmd          (cmd)
    );

    // frames, lru and tag compare
    dcache_sets u_sets (
        .CLK          (CLK),
        .n_rst        (n_rst),
        .cpu_addr     (cpu_req.addr),
        .flush_idx    (flush_idx),
        .cmd          (cmd),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_word     (hit_word),
        .victim_way   (victim_way),
        .victim_frame (victim_frame),
        .flush_frames (flush_frames)
    );

endmodule

/* tb/tb_clock.sv */
module tb_clock #(
    parameter int period       = 20,
    parameter int reset_cycles = 5
) (
    output logic CLK,
    output logic n_rst
);

    initial begin
        CLK = 1'b0;
        forever #(period / 2) CLK = ~CLK;
    end

    // release on a falling edge, away from the active edge
    initial begin
        n_rst = 1'b0;
        repeat (reset_cycles) @(posedge CLK);
        @(negedge CLK);
        n_rst = 1'b1;
    end

endmodule

/* tb/dcache_tb.sv */
module dcache_tb;

    localparam int rand_seed = 32'hbad2_0ba4;
    localparam int mem_words = 1024;
    // worst access is writeback plus refill, four transfers of up to six cycles
    localparam int access_budget  = 200;
    localparam int access_cycles  = 100;
    localparam int timeout_cycles = access_budget * access_cycles;

    logic CLK;
    logic n_rst;
    dcache_pkg::cpu_req_t  cpu_req;
    dcache_pkg::cpu_resp_t cpu_resp;
    dcache_pkg::mem_req_t  mem_req;
    dcache_pkg::mem_resp_t mem_resp = '0;

    dcache_pkg::word_t mem [mem_words];
    dcache_pkg::word_t shadow [mem_words];
    // one entry per transfer with the write flag above the byte address
    logic [32:0] mem_log [$];
    int wait_table [256];
    logic [7:0] wait_ptr = '0;
    logic use_waits = 1'b0;
    logic busy = 1'b0;
    int wait_left = 0;
    logic [31:0] mem_addr;
    int cycle_count = 0;

    tb_clock #(.period(20), .reset_cycles(5)) u_clock (.CLK(CLK), .n_rst(n_rst));

    dcache dut (
        .CLK      (CLK),
        .n_rst    (n_rst),
        .cpu_req  (cpu_req),
        .cpu_resp (cpu_resp),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

    function automatic dcache_pkg::word_t fill_word(input logic [31:0] byte_addr);
        return byte_addr ^ {byte_addr[15:0], byte_addr[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic logic [31:0] make_addr(input logic [5:0] tag, input logic [2:0] idx,
                                              input logic blkoff);
        return {20'd0, tag, idx, blkoff, 2'b00};
    endfunction

    function automatic dcache_pkg::word_t shadow_word(input logic [31:0] byte_addr);
        return shadow[byte_addr[11:2]];
    endfunction

    // memory model answers on the falling edge
    always @(negedge CLK) begin
        if (!n_rst) begin
            busy = 1'b0;
            mem_resp.dwait = 1'b0;
            for (int i = 0; i < mem_words; i++) begin
                mem[i] = fill_word(32'(i) << 2);
            end
        end else if (!(mem_req.ren || mem_req.wen)) begin
            mem_resp.dwait = 1'b0;
        end else begin
            mem_addr = mem_req.addr;
            if (!busy) begin
                busy = 1'b1;
                wait_left = use_waits ? wait_table[wait_ptr] : 0;
                wait_ptr = wait_ptr + 8'd1;
            end
            if (mem_addr[31:12] != '0) begin
                $display("memory access outside the model at address %h", mem_addr);
                abort_run();
            end else if (wait_left > 0) begin
                mem_resp.dwait = 1'b1;
                wait_left--;
            end else begin
                mem_resp.dwait = 1'b0;
                busy = 1'b0;
                mem_log.push_back({mem_req.wen, mem_addr});
                if (mem_req.wen) begin
                    mem[mem_addr[11:2]] = mem_req.store;
                end else begin
                    mem_resp.load = mem[mem_addr[11:2]];
                end
            end
        end
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("run did not finish within %0d cycles", timeout_cycles);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string test_name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERR %s: expected %0h, actual %0h", test_name, expected, actual);
            abort_run();
        end
    endtask

    // hold the request until hit shows at a rising edge
    task automatic access(input logic write, input logic [31:0] addr,
                          input dcache_pkg::word_t data, output dcache_pkg::word_t load);
        cpu_req.ren   = !write;
        cpu_req.wen   = write;
        cpu_req.addr  = addr;
        cpu_req.store = data;
        do begin
            @(posedge CLK);
        end while (!cpu_resp.hit);
        load = cpu_resp.load;
        if (write) begin
            shadow[addr[11:2]] = data;
        end
        @(negedge CLK);
        cpu_req.ren = 1'b0;
        cpu_req.wen = 1'b0;
    endtask

    task automatic expect_transfer(input string test_name, input int pos, input logic wr,
                                   input logic [31:0] addr);
        check(test_name, 64'({wr, addr}), 64'(mem_log[pos]));
    endtask

    task automatic read_miss_then_hit(input logic [2:0] idx);
        string name;
        logic [31:0] base;
        int mark;
        dcache_pkg::word_t load;
        name = $sformatf("read_miss_idx%0d", idx);
        base = make_addr(6'd1, idx, 1'b0);
        mark = mem_log.size();
        access(1'b0, base | 32'd4, '0, load);
        check(name, 64'(shadow_word(base | 32'd4)), 64'(load));
        check(name, 64'd2, 64'(mem_log.size() - mark));
        expect_transfer(name, mark, 1'b0, base);
        expect_transfer(name, mark + 1, 1'b0, base | 32'd4);
        // other word of the block is already in
        access(1'b0, base, '0, load);
        check(name, 64'(shadow_word(base)), 64'(load));
        check(name, 64'd2, 64'(mem_log.size() - mark));
    endtask

    task automatic write_hit_readback(input logic [2:0] idx);
        string name;
        logic [31:0] base;
        int mark;
        dcache_pkg::word_t data;
        dcache_pkg::word_t load;
        name = $sformatf("write_hit_idx%0d", idx);
        base = make_addr(6'd1, idx, 1'b0);
        data = $urandom;
        mark = mem_log.size();
        access(1'b1, base, data, load);
        access(1'b0, base, '0, load);
        check(name, 64'(data), 64'(load));
        check(name, 64'd0, 64'(mem_log.size() - mark));
    endtask

    task automatic write_miss_merge(input logic [2:0] idx);
        string name;
        logic [31:0] base;
        int mark;
        dcache_pkg::word_t data;
        dcache_pkg::word_t load;
        name = $sformatf("write_miss_idx%0d", idx);
        base = make_addr(6'd2, idx, 1'b0);
        data = $urandom;
        mark = mem_log.size();
        access(1'b1, base | 32'd4, data, load);
        check(name, 64'd2, 64'(mem_log.size() - mark));
        expect_transfer(name, mark, 1'b0, base);
        expect_transfer(name, mark + 1, 1'b0, base | 32'd4);
        access(1'b0, base | 32'd4, '0, load);
        check(name, 64'(data), 64'(load));
        access(1'b0, base, '0, load);
        check(name, 64'(shadow_word(base)), 64'(load));
        check(name, 64'd2, 64'(mem_log.size() - mark));
    endtask

    task automatic lru_evict_writeback(input logic [2:0] idx);
        string name;
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] third;
        int mark;
        dcache_pkg::word_t data;
        dcache_pkg::word_t load;
        name = $sformatf("lru_evict_idx%0d", idx);
        first = make_addr(6'd4, idx, 1'b0);
        second = make_addr(6'd5, idx, 1'b0);
        third = make_addr(6'd6, idx, 1'b0);
        data = $urandom;
        access(1'b1, first, data, load);
        access(1'b1, second, $urandom, load);
        // first block becomes most recently used
        access(1'b0, first, '0, load);
        mark = mem_log.size();
        access(1'b0, third | 32'd4, '0, load);
        check(name, 64'(shadow_word(third | 32'd4)), 64'(load));
        check(name, 64'd4, 64'(mem_log.size() - mark));
        expect_transfer(name, mark, 1'b1, second);
        expect_transfer(name, mark + 1, 1'b1, second | 32'd4);
        expect_transfer(name, mark + 2, 1'b0, third);
        expect_transfer(name, mark + 3, 1'b0, third | 32'd4);
        check(name, 64'(shadow_word(second)), 64'(mem[second[11:2]]));
        check(name, 64'(shadow_word(second | 32'd4)), 64'(mem[second[11:2] + 10'd1]));
        access(1'b0, first, '0, load);
        check(name, 64'(data), 64'(load));
        check(name, 64'd4, 64'(mem_log.size() - mark));
    endtask

    task automatic run_access_tests(input logic [2:0] idx_a, input logic [2:0] idx_b,
                                    input logic [2:0] idx_c);
        read_miss_then_hit(idx_a);
        write_hit_readback(idx_a);
        write_miss_merge(idx_b);
        lru_evict_writeback(idx_c);
    endtask

    task automatic halt_flush();
        string name;
        logic [31:0] addr;
        dcache_pkg::word_t expected;
        dcache_pkg::word_t load;
        name = "halt_flush";
        for (int n = 0; n < 40; n++) begin
            addr = {20'd0, 10'($urandom_range(1023, 0)), 2'b00};
            expected = shadow_word(addr);
            if ($urandom_range(1, 0) == 1) begin
                access(1'b1, addr, $urandom, load);
            end else begin
                access(1'b0, addr, '0, load);
                check(name, 64'(expected), 64'(load));
            end
        end
        cpu_req.halt = 1'b1;
        do begin
            @(posedge CLK);
        end while (!cpu_resp.flushed);
        @(negedge CLK);
        check(name, 64'd1, 64'(cpu_resp.flushed));
        for (int i = 0; i < mem_words; i++) begin
            check(name, 64'(shadow[i]), 64'(mem[i]));
        end
    endtask

    initial begin
        void'($urandom(rand_seed));
        cpu_req = '0;
        // wait states of 0 to 5 cycles per transfer
        for (int i = 0; i < 256; i++) begin
            wait_table[i] = $urandom_range(5, 0);
        end
        for (int i = 0; i < mem_words; i++) begin
            shadow[i] = fill_word(32'(i) << 2);
        end
        @(posedge n_rst);
        @(negedge CLK);
        check("reset", 64'd0,
              64'({cpu_resp.hit, cpu_resp.flushed, mem_req.ren, mem_req.wen}));
        run_access_tests(3'd0, 3'd1, 3'd2);
        use_waits = 1'b1;
        run_access_tests(3'd3, 3'd4, 3'd5);
        halt_flush();
        $display("All tests passed!");
        $finish;
    end

endmodule

/* flist.f */
design/dcache_pkg.sv
design/dcache_sets.sv
design/dcache_ctrl.sv
design/dcache.sv
tb/tb_clock.sv
tb/dcache_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = dcache_tb
FLIST     = flist.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Test failures found
PASS_MSG  = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '$(FAIL_MSG)' $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q '$(PASS_MSG)' $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
